// ==== bench/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
    input logic              clk_m1,
    input logic              rst,
    input logic [data_w-1:0] data_i,
    input logic              ready_i,
    input logic [addr_w-1:0] addr_i,
    input logic              rw_i,
    input logic              sync_i,
    input logic              jam_i
);

    // read by the testbench summary
    int unsigned       fail_cnt = 0;
    logic              advance;
    logic              fetch_ill;
    logic              seen_sync;
    logic              was_jmp;
    int unsigned       gap;
    int unsigned       gap_exp;
    logic [data_w-1:0] vec_lo;
    logic [data_w-1:0] vec_hi;
    logic [data_w-1:0] opnd_lo;
    logic [data_w-1:0] opnd_hi;

    // cycles from one fetch to the next, 0 for an opcode that jams
    function automatic int unsigned op_len(input logic [data_w-1:0] op);
        int unsigned n;
        case (op)
            8'ha9, 8'ha2, 8'ha0, 8'h69, 8'h29, 8'h09, 8'h49,
            8'haa, 8'h8a, 8'he8, 8'hc8, 8'hca, 8'h88,
            8'h18, 8'h38, 8'hea:                      n = 2;
            8'ha5, 8'ha6, 8'ha4, 8'h85, 8'h86, 8'h84: n = 3;
            8'had, 8'hae, 8'hac, 8'h8d, 8'h8e, 8'h8c: n = 4;
            8'h4c:                                    n = 3;
            default:                                  n = 0;
        endcase
        return n;
    endfunction

    // writes never stall
    assign advance = ready_i | ~rw_i;
    assign fetch_ill = sync_i && advance && (op_len(data_i) == 0);

    // bus trace, counts advancing cycles since the last fetch
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            seen_sync <= 1'b0;
            was_jmp <= 1'b0;
            gap <= 0;
            gap_exp <= 0;
        end else if (advance) begin
            if (addr_i == rst_vector) begin
                vec_lo <= data_i;
            end
            if (addr_i == rst_vector + addr_w'(1)) begin
                vec_hi <= data_i;
            end
            if (sync_i) begin
                seen_sync <= 1'b1;
                gap <= 1;
                gap_exp <= op_len(data_i);
                was_jmp <= (data_i == 8'h4c);
            end else begin
                gap <= gap + 1;
                // operand bytes follow the opcode
                if (gap == 1) begin
                    opnd_lo <= data_i;
                end
                if (gap == 2) begin
                    opnd_hi <= data_i;
                end
            end
        end
    end

    // first fetch comes from the reset vector
    a_reset_vector: assert property (@(posedge clk_m1) disable iff (rst)
        (sync_i && !seen_sync) |-> (addr_i == {vec_hi, vec_lo}))
    else begin
        fail_cnt++;
        $error("first opcode fetch is not at the reset vector");
    end

    a_spacing: assert property (@(posedge clk_m1) disable iff (rst)
        (sync_i && seen_sync && gap_exp != 0) |-> (gap == gap_exp))
    else begin
        fail_cnt++;
        $error("instruction took %0d cycles, expected %0d", gap, gap_exp);
    end

    // jmp target shows on the next fetch
    a_jmp_target: assert property (@(posedge clk_m1) disable iff (rst)
        (sync_i && seen_sync && was_jmp) |-> (addr_i == {opnd_hi, opnd_lo}))
    else begin
        fail_cnt++;
        $error("fetch after JMP is not at the jump target");
    end

    a_stall_hold: assert property (@(posedge clk_m1) disable iff (rst)
        (!ready_i && rw_i) |=> ($stable(addr_i) && $stable(rw_i)))
    else begin
        fail_cnt++;
        $error("address or rw moved during a stalled read");
    end

    // a store is the last cycle of its instruction
    a_store_last: assert property (@(posedge clk_m1) disable iff (rst)
        !rw_i |=> sync_i)
    else begin
        fail_cnt++;
        $error("write cycle not followed by an opcode fetch");
    end

    a_jam_on_illegal: assert property (@(posedge clk_m1) disable iff (rst)
        fetch_ill |=> jam_i)
    else begin
        fail_cnt++;
        $error("illegal opcode did not jam the core");
    end

    a_jam_cause: assert property (@(posedge clk_m1) disable iff (rst)
        $rose(jam_i) |-> $past(fetch_ill))
    else begin
        fail_cnt++;
        $error("jam raised without an illegal opcode fetch");
    end

    // jammed core stays quiet on the bus
    a_jam_sticky: assert property (@(posedge clk_m1) disable iff (rst)
        jam_i |=> (jam_i && !sync_i && rw_i))
    else begin
        fail_cnt++;
        $error("core left the jam state or used the bus");
    end

endmodule

bind cpu_top cpu_assert u_chk (
    .clk_m1  (clk_m1),
    .rst     (rst),
    .data_i  (data_i),
    .ready_i (ready_i),
    .addr_i  (addr_o),
    .rw_i    (rw_o),
    .sync_i  (sync_o),
    .jam_i   (jam_o)
);

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int period = 40;
    localparam int rst_cycles = 4;
    // program with stalls and the jam tail runs about 130 cycles
    localparam int watchdog_cycles = 400;
    localparam logic [addr_w-1:0] prog_org = 16'h0200;
    localparam logic [addr_w-1:0] jump_org = 16'h0400;

    logic              clk_m1 = 1'b0;
    logic              rst;
    logic              ready_i;
    logic [data_w-1:0] data_i;
    logic [addr_w-1:0] addr_o;
    logic [data_w-1:0] dor_o;
    logic              rw_o;
    logic              sync_o;
    logic              jam_o;

    logic [data_w-1:0] mem [0:65535];
    logic [addr_w-1:0] exp_addr [$];
    logic [data_w-1:0] exp_data [$];

    // assembler position and register model for the expected stores
    logic [addr_w-1:0] pc_asm;
    logic [data_w-1:0] m_a;
    logic [data_w-1:0] m_x;
    logic [data_w-1:0] m_y;
    logic              m_c;

    integer            seed = 32'h3e76;
    int                errors = 0;
    int                stores = 0;
    int unsigned       chk_fails;
    logic              stall_en = 1'b1;
    logic              wr_pend = 1'b0;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;

    cpu_top uut (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .data_i  (data_i),
        .ready_i (ready_i),
        .addr_o  (addr_o),
        .dor_o   (dor_o),
        .rw_o    (rw_o),
        .sync_o  (sync_o),
        .jam_o   (jam_o)
    );

    // memory answers in the same cycle
    assign data_i = mem[addr_o];

    always #(period / 2) clk_m1 = ~clk_m1;

    task automatic emit(input logic [data_w-1:0] b);
        mem[pc_asm] = b;
        pc_asm = pc_asm + 16'd1;
    endtask

    // zero page takes one address byte and absolute two
    task automatic emit_operand(input logic [data_w-1:0] op, input logic [addr_w-1:0] a);
        emit(a[7:0]);
        if (op[3]) begin
            emit(a[15:8]);
        end
    endtask

    task automatic op_imm(input logic [data_w-1:0] op, input logic [data_w-1:0] v);
        logic [data_w:0] sum;
        emit(op);
        emit(v);
        sum = {1'b0, m_a} + {1'b0, v} + {8'd0, m_c};
        case (op)
            8'ha9: m_a = v;
            8'ha2: m_x = v;
            8'ha0: m_y = v;
            8'h69: {m_c, m_a} = sum;
            8'h29: m_a = m_a & v;
            8'h09: m_a = m_a | v;
            8'h49: m_a = m_a ^ v;
            default: begin
            end
        endcase
    endtask

    task automatic op_impl(input logic [data_w-1:0] op);
        emit(op);
        case (op)
            8'h18: m_c = 1'b0;
            8'h38: m_c = 1'b1;
            8'haa: m_x = m_a;
            8'h8a: m_a = m_x;
            8'he8: m_x = m_x + 8'd1;
            8'hc8: m_y = m_y + 8'd1;
            8'hca: m_x = m_x - 8'd1;
            8'h88: m_y = m_y - 8'd1;
            // nop
            default: begin
            end
        endcase
    endtask

    task automatic load(input logic [data_w-1:0] op, input logic [addr_w-1:0] a,
                        input logic [data_w-1:0] preset);
        mem[a] = preset;
        emit(op);
        emit_operand(op, a);
        case (op)
            8'ha5, 8'had: m_a = preset;
            8'ha6, 8'hae: m_x = preset;
            default:      m_y = preset;
        endcase
    endtask

    task automatic store(input logic [data_w-1:0] op, input logic [addr_w-1:0] a);
        emit(op);
        emit_operand(op, a);
        exp_addr.push_back(a);
        case (op)
            8'h85, 8'h8d: exp_data.push_back(m_a);
            8'h86, 8'h8e: exp_data.push_back(m_x);
            default:      exp_data.push_back(m_y);
        endcase
    endtask

    task automatic build_program();
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5c;
        end
        mem[rst_vector] = prog_org[7:0];
        mem[rst_vector + 16'd1] = prog_org[15:8];
        pc_asm = prog_org;
        m_a = 8'h00;
        m_x = 8'h00;
        m_y = 8'h00;
        m_c = 1'b0;
        // alu part with stalls enabled
        op_imm(8'ha9, 8'h37);
        store(8'h85, 16'h0080);
        op_impl(8'h18);
        op_imm(8'h69, 8'he0);
        store(8'h85, 16'h0081);
        // carry out of the last sum feeds this one
        op_imm(8'h69, 8'h05);
        store(8'h85, 16'h0082);
        op_impl(8'h38);
        op_imm(8'h69, 8'h10);
        store(8'h8d, 16'h0300);
        op_imm(8'h29, 8'hf3);
        store(8'h85, 16'h0083);
        op_imm(8'h09, 8'h41);
        store(8'h85, 16'h0084);
        op_imm(8'h49, 8'hff);
        store(8'h85, 16'h0085);
        op_impl(8'haa);
        op_impl(8'he8);
        store(8'h86, 16'h0086);
        op_imm(8'ha0, 8'h00);
        op_impl(8'h88);
        store(8'h84, 16'h0087);
        op_impl(8'h8a);
        store(8'h8d, 16'h0301);
        emit(8'h4c);
        emit_operand(8'h4c, jump_org);
        // load paths and a closing illegal opcode
        pc_asm = jump_org;
        load(8'ha5, 16'h0040, 8'h5a);
        store(8'h85, 16'h0088);
        load(8'hae, 16'h0310, 8'hc3);
        store(8'h8e, 16'h0302);
        load(8'ha4, 16'h0041, 8'h96);
        store(8'h8c, 16'h0303);
        op_impl(8'hea);
        emit(8'h02);
    endtask

    task automatic check_store(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
        logic [addr_w-1:0] ea;
        logic [data_w-1:0] ed;
        stores++;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("store of %h to %h came after the last store of the program", d, a);
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (a == ea && d == ed) else begin
                errors++;
                $display("error %0t: store wrote %h to %h, expected %h to %h",
                         $time, d, a, ed, ea);
            end
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk_m1) begin
        wr_pend <= !rst && !rw_o;
        wr_addr <= addr_o;
        wr_data <= dor_o;
        if (!rst && !rw_o) begin
            check_store(addr_o, dor_o);
        end
    end

    always @(posedge clk_m1) begin
        if (wr_pend) begin
            mem[wr_addr] = wr_data;
        end
    end

    // ready low a quarter of the time until the jump target is fetched
    always @(posedge clk_m1) begin
        #2;
        if (sync_o && addr_o == jump_org) begin
            stall_en = 1'b0;
        end
        if (!stall_en) begin
            ready_i = 1'b1;
        end else begin
            ready_i = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        rst = 1'b1;
        ready_i = 1'b1;
        build_program();
        repeat (rst_cycles) @(posedge clk_m1);
        #2;
        rst = 1'b0;
        // jam marks the end of the program
        wait (jam_o === 1'b1);
        repeat (8) @(posedge clk_m1);
        #2;
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d stores of the program never took place", exp_addr.size());
        end
        chk_fails = uut.u_chk.fail_cnt;
        $display("stores: %0d, errors: %0d, assertion failures: %0d",
                 stores, errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * period);
        $display("timeout: the core did not jam within %0d cycles", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/cpu_pkg.sv
logic/op_decode.sv
logic/seq_fsm.sv
logic/addr_unit.sv
logic/exec_unit.sv
logic/cpu_top.sv
bench/cpu_assert.sv
bench/tb_cpu.sv

// ==== logic/addr_unit.sv ====
`timescale 1ns/1ps

module addr_unit import cpu_pkg::*; (
    input  logic              clk_m1,
    input  logic              rst,
    input  logic              advance_i,
    input  ctrl_t             ctrl_i,
    input  logic [data_w-1:0] data_i,
    input  logic [data_w-1:0] data_lat_i,
    output logic [addr_w-1:0] addr_o
);

    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] pc_next;
    logic [addr_w-1:0] adr_next;

    always_comb begin
        // pc after an optional increment
        pc_next = ctrl_i.inc_pc ? pc + addr_w'(1) : pc;

        case (ctrl_i.adr_src)
            // high byte live on the bus, low byte held from last cycle
            adr_abs:  adr_next = {data_i, data_lat_i};
            adr_zpg:  adr_next = {{(addr_w-data_w){1'b0}}, data_i};
            adr_hold: adr_next = addr_o;
            // vector high byte follows the low byte
            adr_vec:  adr_next = rst_vector + addr_w'(1);
            default:  adr_next = pc_next;
        endcase
    end

    // external address is registered, so it trails the control word by a cycle
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            pc <= rst_vector;
            addr_o <= rst_vector;
        end else if (advance_i) begin
            addr_o <= adr_next;
            if (ctrl_i.jump) begin
                pc <= adr_next;
            end else begin
                pc <= pc_next;
            end
        end
    end

endmodule

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;

    // low byte of the reset vector, high byte at the next address
    localparam logic [addr_w-1:0] rst_vector = 16'hfffc;

    // flag bit positions in P
    localparam int fl_c = 0;
    localparam int fl_z = 1;
    localparam int fl_i = 2;
    localparam int fl_u = 5;
    localparam int fl_n = 7;

    // irq masked and the unused bit reads high after reset
    localparam logic [data_w-1:0] initial_status =
        data_w'(1 << fl_i) | data_w'(1 << fl_u);

    // ir holds a NOP until the first opcode fetch
    localparam logic [data_w-1:0] op_nop = 8'hea;

    // addressing classes kept in this core
    typedef enum logic [2:0] {
        cls_impl,
        cls_imm,
        cls_zpg,
        cls_abs,
        cls_jmp,
        cls_ill
    } op_class_t;

    // operand b is the selected source, operand a is always A
    typedef enum logic [2:0] {
        alu_pass,
        alu_sum,
        alu_and,
        alu_or,
        alu_eor,
        alu_inc,
        alu_dec
    } alu_op_t;

    // register select, reg_mem is the latched data byte
    typedef enum logic [2:0] {
        reg_none,
        reg_a,
        reg_x,
        reg_y,
        reg_mem
    } reg_sel_t;

    // t1 is the opcode fetch cycle, t0 the last cycle of a memory op
    typedef enum logic [2:0] {
        st_t0,
        st_t1,
        st_t2,
        st_t3,
        st_vl,
        st_vh,
        st_jam
    } t_state_t;

    // where the next address comes from
    typedef enum logic [2:0] {
        adr_pc,
        adr_abs,
        adr_zpg,
        adr_hold,
        adr_vec
    } adr_src_t;

    // decoded operation, 32 bits
    typedef struct packed {
        op_class_t         op_class;
        alu_op_t           alu_op;
        reg_sel_t          src;
        reg_sel_t          dst;
        logic              mem_wr;
        logic              upd_nz;
        logic              upd_c;
        logic [data_w-1:0] set_mask;
        logic [data_w-1:0] clr_mask;
        logic              two_cycle;
    } dec_t;

    // per-cycle control word, 9 bits
    typedef struct packed {
        adr_src_t adr_src;
        logic     inc_pc;
        logic     jump;
        logic     load_ir;
        logic     exec;
        logic     write_mem;
        logic     latch_low;
    } ctrl_t;

endpackage

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic              clk_m1,
    input  logic              rst,
    input  logic [data_w-1:0] data_i,
    input  logic              ready_i,
    output logic [addr_w-1:0] addr_o,
    output logic [data_w-1:0] dor_o,
    output logic              rw_o,
    output logic              sync_o,
    output logic              jam_o
);

    dec_t              dec;
    ctrl_t             ctrl;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] data_lat;
    logic              advance;

    // writes never wait for ready
    assign advance = ready_i | ~rw_o;

    op_decode u_decode (
        .ir_i  (ir),
        .dec_o (dec)
    );

    seq_fsm u_seq (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .ready_i (ready_i),
        .dec_i   (dec),
        .ctrl_o  (ctrl),
        .rw_o    (rw_o),
        .sync_o  (sync_o),
        .jam_o   (jam_o)
    );

    addr_unit u_addr (
        .clk_m1     (clk_m1),
        .rst        (rst),
        .advance_i  (advance),
        .ctrl_i     (ctrl),
        .data_i     (data_i),
        .data_lat_i (data_lat),
        .addr_o     (addr_o)
    );

    exec_unit u_exec (
        .clk_m1     (clk_m1),
        .rst        (rst),
        .advance_i  (advance),
        .ctrl_i     (ctrl),
        .dec_i      (dec),
        .data_i     (data_i),
        .ir_o       (ir),
        .data_lat_o (data_lat),
        .dor_o      (dor_o)
    );

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
    input  logic              clk_m1,
    input  logic              rst,
    input  logic              advance_i,
    input  ctrl_t             ctrl_i,
    input  dec_t              dec_i,
    input  logic [data_w-1:0] data_i,
    output logic [data_w-1:0] ir_o,
    output logic [data_w-1:0] data_lat_o,
    output logic [data_w-1:0] dor_o
);

    logic [data_w-1:0] a;
    logic [data_w-1:0] x;
    logic [data_w-1:0] y;
    logic [data_w-1:0] p;
    logic [data_w-1:0] alu_b;
    logic [data_w-1:0] alu_r;
    logic              alu_c;

    // opcode register, loaded in the fetch cycle
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            ir_o <= op_nop;
        end else if (advance_i && ctrl_i.load_ir) begin
            ir_o <= data_i;
        end
    end

    // operand or low address byte
    always_ff @(posedge clk_m1) begin
        if (advance_i && ctrl_i.latch_low) begin
            data_lat_o <= data_i;
        end
    end

    // source select feeds the alu b side and the store data
    always_comb begin
        case (dec_i.src)
            reg_a:   alu_b = a;
            reg_x:   alu_b = x;
            reg_y:   alu_b = y;
            reg_mem: alu_b = data_lat_o;
            default: alu_b = '0;
        endcase
    end

    always_comb begin
        // carry only changes on a sum
        alu_c = p[fl_c];
        case (dec_i.alu_op)
            alu_sum: begin
                {alu_c, alu_r} = {1'b0, a} + {1'b0, alu_b} +
                                 {{data_w{1'b0}}, p[fl_c]};
            end
            alu_and: alu_r = a & alu_b;
            alu_or:  alu_r = a | alu_b;
            alu_eor: alu_r = a ^ alu_b;
            alu_inc: alu_r = alu_b + data_w'(1);
            alu_dec: alu_r = alu_b - data_w'(1);
            default: alu_r = alu_b;
        endcase
    end

    // commit at the end of the next fetch cycle
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a <= '0;
            x <= '0;
            y <= '0;
            p <= initial_status;
        end else if (advance_i && ctrl_i.exec) begin
            p <= (p & ~dec_i.clr_mask) | dec_i.set_mask;
            if (dec_i.upd_c) begin
                p[fl_c] <= alu_c;
            end
            if (dec_i.upd_nz) begin
                p[fl_z] <= ~|alu_r;
                p[fl_n] <= alu_r[data_w-1];
            end
            case (dec_i.dst)
                reg_a:   a <= alu_r;
                reg_x:   x <= alu_r;
                reg_y:   y <= alu_r;
                default: begin
                end
            endcase
        end
    end

    // store byte only on a write cycle
    assign dor_o = ctrl_i.write_mem ? alu_b : '0;

endmodule

// ==== logic/op_decode.sv ====
`timescale 1ns/1ps

module op_decode import cpu_pkg::*; (
    input  logic [data_w-1:0] ir_i,
    output dec_t              dec_o
);

    // low two opcode bits pick the register for loads and stores
    function automatic reg_sel_t reg_of(input logic [1:0] cc);
        reg_sel_t r;
        case (cc)
            2'b01:   r = reg_a;
            2'b10:   r = reg_x;
            default: r = reg_y;
        endcase
        return r;
    endfunction

    // bits 3:2 give the mode of a load or store
    function automatic op_class_t mode_of(input logic [1:0] bb);
        op_class_t c;
        case (bb)
            2'b01:   c = cls_zpg;
            2'b11:   c = cls_abs;
            default: c = cls_imm;
        endcase
        return c;
    endfunction

    always_comb begin
        dec_o = '0;
        dec_o.op_class = cls_ill;
        dec_o.alu_op = alu_pass;
        dec_o.src = reg_none;
        dec_o.dst = reg_none;

        // predecode of the 2 cycle imm and implied ops from opcode bits alone
        dec_o.two_cycle = (ir_i ==? 8'b1??_000_?0) ||
                          ((ir_i ==? 8'b???_010_??) && (ir_i !=? 8'b0??_010_00)) ||
                          (ir_i ==? 8'b???_110_?0);

        case (ir_i)
            // LDA, LDX, LDY
            8'ha9, 8'ha5, 8'had, 8'ha2, 8'ha6, 8'hae, 8'ha0, 8'ha4, 8'hac: begin
                dec_o.op_class = mode_of(ir_i[3:2]);
                dec_o.src = reg_mem;
                dec_o.dst = reg_of(ir_i[1:0]);
                dec_o.upd_nz = 1'b1;
            end
            // STA, STX, STY
            8'h85, 8'h8d, 8'h86, 8'h8e, 8'h84, 8'h8c: begin
                dec_o.op_class = mode_of(ir_i[3:2]);
                dec_o.src = reg_of(ir_i[1:0]);
                dec_o.mem_wr = 1'b1;
            end
            // ADC, AND, ORA, EOR immediate
            8'h69, 8'h29, 8'h09, 8'h49: begin
                dec_o.op_class = cls_imm;
                dec_o.src = reg_mem;
                dec_o.dst = reg_a;
                dec_o.upd_nz = 1'b1;
                case (ir_i[7:5])
                    3'b011: begin
                        dec_o.alu_op = alu_sum;
                        dec_o.upd_c = 1'b1;
                    end
                    3'b001:  dec_o.alu_op = alu_and;
                    3'b000:  dec_o.alu_op = alu_or;
                    default: dec_o.alu_op = alu_eor;
                endcase
            end
            // register increment and decrement
            8'he8, 8'hc8, 8'hca, 8'h88: begin
                dec_o.op_class = cls_impl;
                dec_o.src = (ir_i == 8'he8 || ir_i == 8'hca) ? reg_x : reg_y;
                dec_o.dst = dec_o.src;
                dec_o.alu_op = (ir_i[7:5] == 3'b111 || ir_i == 8'hc8) ? alu_inc : alu_dec;
                dec_o.upd_nz = 1'b1;
            end
            // transfers go through the alu as a pass
            8'haa, 8'h8a: begin
                dec_o.op_class = cls_impl;
                dec_o.src = ir_i[5] ? reg_a : reg_x;
                dec_o.dst = ir_i[5] ? reg_x : reg_a;
                dec_o.upd_nz = 1'b1;
            end
            8'h18: begin
                dec_o.op_class = cls_impl;
                dec_o.clr_mask[fl_c] = 1'b1;
            end
            8'h38: begin
                dec_o.op_class = cls_impl;
                dec_o.set_mask[fl_c] = 1'b1;
            end
            8'hea: dec_o.op_class = cls_impl;
            8'h4c: dec_o.op_class = cls_jmp;
            // anything else jams the core
            default: dec_o.op_class = cls_ill;
        endcase
    end

endmodule

// ==== logic/seq_fsm.sv ====
`timescale 1ns/1ps

module seq_fsm import cpu_pkg::*; (
    input  logic  clk_m1,
    input  logic  rst,
    input  logic  ready_i,
    input  dec_t  dec_i,
    output ctrl_t ctrl_o,
    output logic  rw_o,
    output logic  sync_o,
    output logic  jam_o
);

    t_state_t state;
    t_state_t next_state;
    logic     advance;

    // ready only stalls read cycles
    assign advance = ready_i | ~rw_o;

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state <= st_vl;
        end else if (advance) begin
            state <= next_state;
        end
    end

    always_comb begin
        ctrl_o = '0;
        ctrl_o.adr_src = adr_pc;
        next_state = state;

        case (state)
            // bus shows vector low, capture it and point at vector high
            st_vl: begin
                ctrl_o.latch_low = 1'b1;
                ctrl_o.adr_src = adr_vec;
                next_state = st_vh;
            end
            // vector high on data_i, pc and bus take the full vector
            st_vh: begin
                ctrl_o.adr_src = adr_abs;
                ctrl_o.jump = 1'b1;
                next_state = st_t1;
            end
            // opcode fetch, previous op commits at the end of this cycle
            st_t1: begin
                ctrl_o.exec = 1'b1;
                ctrl_o.load_ir = 1'b1;
                ctrl_o.inc_pc = 1'b1;
                next_state = st_t2;
            end
            // first operand byte, ir now valid
            st_t2: begin
                if (dec_i.op_class == cls_ill) begin
                    ctrl_o.adr_src = adr_hold;
                    next_state = st_jam;
                end else if (dec_i.two_cycle) begin
                    // implied reads a dummy byte without moving pc
                    ctrl_o.latch_low = 1'b1;
                    ctrl_o.inc_pc = (dec_i.op_class == cls_imm);
                    next_state = st_t1;
                end else begin
                    ctrl_o.latch_low = 1'b1;
                    ctrl_o.inc_pc = 1'b1;
                    case (dec_i.op_class)
                        cls_zpg: begin
                            ctrl_o.adr_src = adr_zpg;
                            next_state = st_t0;
                        end
                        cls_abs, cls_jmp: next_state = st_t3;
                        default: next_state = st_jam;
                    endcase
                end
            end
            // high address byte, jmp loads pc here
            st_t3: begin
                ctrl_o.inc_pc = 1'b1;
                ctrl_o.adr_src = adr_abs;
                ctrl_o.jump = (dec_i.op_class == cls_jmp);
                next_state = (dec_i.op_class == cls_jmp) ? st_t1 : st_t0;
            end
            // data access, store or load operand
            st_t0: begin
                ctrl_o.write_mem = dec_i.mem_wr;
                ctrl_o.latch_low = ~dec_i.mem_wr;
                next_state = st_t1;
            end
            // jammed until reset
            default: begin
                ctrl_o.adr_src = adr_hold;
                next_state = st_jam;
            end
        endcase
    end

    assign rw_o = ~ctrl_o.write_mem;
    assign sync_o = (state == st_t1);
    // jam shows already in the cycle after the bad fetch
    assign jam_o = (state == st_jam) ||
                   ((state == st_t2) && (dec_i.op_class == cls_ill));

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu -f compile.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let assertion failures reach the testbench summary
./obj_dir/tb_cpu_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
exit 0
